//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := rps_game_tb
FILELIST  := project.f
OBJDIR    := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "Test OK"

clean:
	rm -rf $(OBJDIR)

//--- project.f
verilog/rps_rules_pkg.sv
verilog/rps_hw_pkg.sv
verilog/move_queue.sv
verilog/opponent_strategy.sv
verilog/round_judge.sv
verilog/score_display.sv
verilog/round_control.sv
verilog/rps_game_top.sv
testbench/tb_clock_gen.sv
testbench/rps_game_props.sv
testbench/rps_game_tb.sv

//--- testbench/rps_game_props.sv
// rps_game_props: bound concurrent assertions on the game top level
`timescale 1ns/1ps

module rps_game_props #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic                             clock,
	input logic                             reset,
	input logic                             move_valid,
	input logic                             result_valid,
	input logic [1:0]                       com_move_shown,
	input logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_count,
	input rps_hw_pkg::round_state_t         state
);

	single_result_pulse: assert property (@(posedge clock) disable iff (!reset)
		result_valid |=> !result_valid)
		else $error("result_valid high for two cycles");

	legal_com_move: assert property (@(posedge clock) disable iff (!reset)
		com_move_shown != 2'd3)
		else $error("com_move_shown holds an illegal code");

	no_push_when_full: assert property (@(posedge clock) disable iff (!reset)
		!(move_valid && queue_count == QUEUE_DEPTH))
		else $error("move queue pushed while full");

	idle_after_reset: assert property (@(posedge clock)
		$rose(reset) |-> state == rps_hw_pkg::ST_IDLE)
		else $error("round FSM not idle after reset");

endmodule

bind rps_game_top rps_game_props #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_rps_game_props (
	.clock(clock), .reset(reset), .move_valid(move_valid),
	.result_valid(result_valid), .com_move_shown(com_move_shown),
	.queue_count(u_move_queue.count), .state(u_round_control.state)
);

//--- testbench/rps_game_tb.sv
// rps_game_tb: stimulus table, reference model, compare tasks and summary
`timescale 1ns/1ps

module rps_game_tb;

	localparam int QUEUE_DEPTH = 4;
	localparam int COUNT_WIDTH = 8;
	localparam int TIMEOUT     = 200; // cycles per wait
	localparam int NUM_TBL     = 10;
	localparam int SEG_W       = rps_hw_pkg::SEG_WIDTH;
	localparam int SCORE_W     = rps_rules_pkg::SCORE_WIDTH;

	logic                                  clock, reset, move_valid, credit_return, result_valid;
	rps_rules_pkg::move_t                  move, user_move_shown, com_move_shown;
	rps_rules_pkg::strategy_t              strategy;
	rps_rules_pkg::outcome_t               outcome;
	logic [rps_rules_pkg::SCORE_WIDTH-1:0] user_score, com_score, exp_uscore, exp_cscore;
	logic [rps_hw_pkg::SEG_WIDTH-1:0]      hex0, hex1, hex2, hex3, hex4, hex5;

	int value_errors = 0;
	int other_errors = 0;
	int sent = 0;
	int returned = 0;
	bit wrapped = 0;
	int model_cnt [3][3];
	rps_rules_pkg::move_t model_ctx;

	// captured results, oldest first
	rps_rules_pkg::move_t                  q_user [$], q_com [$];
	rps_rules_pkg::outcome_t               q_out [$];
	logic [rps_rules_pkg::SCORE_WIDTH-1:0] q_us [$], q_cs [$];
	logic [6*SEG_W-1:0]                    q_hex [$]; // hex5 down to hex0

	// hand-computed markov rounds from reset, then two cyclic rounds
	string tbl_name [NUM_TBL] = '{"mk_empty_row", "mk_learned_rock", "mk_scissor_row_empty",
		"mk_paper_row_empty", "mk_tie_rock_row", "mk_prefer_rock", "mk_paper_row",
		"mk_scissor_row", "cyc_paper", "cyc_scissor"};
	rps_rules_pkg::strategy_t tbl_strat [NUM_TBL] = '{rps_rules_pkg::STRAT_MARKOV,
		rps_rules_pkg::STRAT_MARKOV, rps_rules_pkg::STRAT_MARKOV, rps_rules_pkg::STRAT_MARKOV,
		rps_rules_pkg::STRAT_MARKOV, rps_rules_pkg::STRAT_MARKOV, rps_rules_pkg::STRAT_MARKOV,
		rps_rules_pkg::STRAT_MARKOV, rps_rules_pkg::STRAT_CYCLIC, rps_rules_pkg::STRAT_CYCLIC};
	rps_rules_pkg::move_t tbl_user [NUM_TBL] = '{rps_rules_pkg::MOVE_ROCK,
		rps_rules_pkg::MOVE_SCISSOR, rps_rules_pkg::MOVE_PAPER, rps_rules_pkg::MOVE_ROCK,
		rps_rules_pkg::MOVE_ROCK, rps_rules_pkg::MOVE_PAPER, rps_rules_pkg::MOVE_SCISSOR,
		rps_rules_pkg::MOVE_ROCK, rps_rules_pkg::MOVE_PAPER, rps_rules_pkg::MOVE_SCISSOR};
	rps_rules_pkg::move_t tbl_com [NUM_TBL] = '{rps_rules_pkg::MOVE_PAPER,
		rps_rules_pkg::MOVE_PAPER, rps_rules_pkg::MOVE_PAPER, rps_rules_pkg::MOVE_PAPER,
		rps_rules_pkg::MOVE_PAPER, rps_rules_pkg::MOVE_PAPER, rps_rules_pkg::MOVE_PAPER,
		rps_rules_pkg::MOVE_SCISSOR, rps_rules_pkg::MOVE_ROCK, rps_rules_pkg::MOVE_ROCK};
	rps_rules_pkg::outcome_t tbl_out [NUM_TBL] = '{rps_rules_pkg::OUT_COM_WIN,
		rps_rules_pkg::OUT_USER_WIN, rps_rules_pkg::OUT_DRAW, rps_rules_pkg::OUT_COM_WIN,
		rps_rules_pkg::OUT_COM_WIN, rps_rules_pkg::OUT_DRAW, rps_rules_pkg::OUT_USER_WIN,
		rps_rules_pkg::OUT_USER_WIN, rps_rules_pkg::OUT_DRAW, rps_rules_pkg::OUT_DRAW};

	tb_clock_gen u_clock_gen (.clock(clock), .reset(reset));

	rps_game_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .COUNT_WIDTH(COUNT_WIDTH)) u_rps_game_top (.*);

	function automatic logic [SEG_W-1:0] seg_pattern(input logic [3:0] nib);
		logic [SEG_W-1:0] pats [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
			7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
		return pats[nib];
	endfunction

	function automatic rps_rules_pkg::move_t beats(input rps_rules_pkg::move_t m);
		if (m == rps_rules_pkg::MOVE_ROCK) return rps_rules_pkg::MOVE_PAPER;
		if (m == rps_rules_pkg::MOVE_SCISSOR) return rps_rules_pkg::MOVE_ROCK;
		return rps_rules_pkg::MOVE_SCISSOR;
	endfunction

	function automatic rps_rules_pkg::outcome_t rule_outcome(input rps_rules_pkg::move_t u,
		input rps_rules_pkg::move_t c);
		if (u == c) return rps_rules_pkg::OUT_DRAW;
		if (u == beats(c)) return rps_rules_pkg::OUT_USER_WIN;
		return rps_rules_pkg::OUT_COM_WIN;
	endfunction

	function automatic rps_rules_pkg::move_t model_com();
		int best = 0;
		for (int j = 1; j < 3; j++)
			if (model_cnt[model_ctx][j] > model_cnt[model_ctx][best]) best = j; // low code on ties
		return beats(rps_rules_pkg::move_t'(2'(best)));
	endfunction

	task automatic check_move(string name, rps_rules_pkg::move_t exp, rps_rules_pkg::move_t act);
		if (act !== exp) begin
			value_errors++;
			$display("ERROR %s: move expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_outcome(string name, rps_rules_pkg::outcome_t exp,
		rps_rules_pkg::outcome_t act);
		if (act !== exp) begin
			value_errors++;
			$display("ERROR %s: outcome expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_score(string name, logic [SCORE_W-1:0] exp, logic [SCORE_W-1:0] act);
		if (act !== exp) begin
			value_errors++;
			$display("ERROR %s: score expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_seg(string name, logic [SEG_W-1:0] exp, logic [SEG_W-1:0] act);
		if (act !== exp) begin
			value_errors++;
			$display("ERROR %s: segments expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_display(string name, logic [SCORE_W-1:0] us, logic [SCORE_W-1:0] cs,
		rps_rules_pkg::move_t um, rps_rules_pkg::move_t cm, logic [6*SEG_W-1:0] act);
		check_seg({name, " hex0"}, seg_pattern(us[3:0]), act[0 +: SEG_W]);
		check_seg({name, " hex1"}, seg_pattern(us[SCORE_W-1 -: 4]), act[SEG_W +: SEG_W]);
		check_seg({name, " hex2"}, seg_pattern({2'b00, um}), act[2*SEG_W +: SEG_W]);
		check_seg({name, " hex3"}, seg_pattern({2'b00, cm}), act[3*SEG_W +: SEG_W]);
		check_seg({name, " hex4"}, seg_pattern(cs[3:0]), act[4*SEG_W +: SEG_W]);
		check_seg({name, " hex5"}, seg_pattern(cs[SCORE_W-1 -: 4]), act[5*SEG_W +: SEG_W]);
	endtask

	// sample registered outputs before they change at this edge
	always @(posedge clock) begin
		if (credit_return) returned++;
		if (result_valid) begin
			q_user.push_back(user_move_shown);
			q_com.push_back(com_move_shown);
			q_out.push_back(outcome);
			q_us.push_back(user_score);
			q_cs.push_back(com_score);
			q_hex.push_back({hex5, hex4, hex3, hex2, hex1, hex0});
		end
	end

	task automatic give_up(string what);
		other_errors++;
		$display("timeout while waiting for %s", what);
		$display("errors: value %0d, other %0d", value_errors, other_errors);
		$display("Test FAILED");
		$finish;
	endtask

	task automatic send_move(rps_rules_pkg::strategy_t s, rps_rules_pkg::move_t m);
		int n = 0;
		@(negedge clock);
		move_valid = 1'b0;
		while (sent - returned >= QUEUE_DEPTH) begin
			@(negedge clock);
			n++;
			if (n > TIMEOUT) give_up("a credit to come back");
		end
		move_valid = 1'b1;
		move       = m;
		strategy   = s;
		sent++;
	endtask

	task automatic release_input();
		@(negedge clock);
		move_valid = 1'b0;
	endtask

	task automatic collect_round(string name, rps_rules_pkg::strategy_t s,
		rps_rules_pkg::move_t u, output rps_rules_pkg::move_t com_seen,
		output rps_rules_pkg::outcome_t out_seen);
		int n = 0;
		rps_rules_pkg::move_t exp_com;
		rps_rules_pkg::outcome_t exp_out;
		while (q_user.size() == 0) begin
			@(negedge clock);
			n++;
			if (n > TIMEOUT) give_up("result_valid");
		end
		com_seen = q_com.pop_front();
		out_seen = q_out.pop_front();
		if (s == rps_rules_pkg::STRAT_MARKOV) begin
			exp_com = model_com();
			check_move({name, " com"}, exp_com, com_seen);
		end else begin
			exp_com = com_seen;
			if (2'(com_seen) == 2'd3) begin
				other_errors++;
				$display("%s: cyclic player showed an illegal move", name);
			end
		end
		exp_out = rule_outcome(u, exp_com);
		if (exp_out == rps_rules_pkg::OUT_USER_WIN) begin
			if (exp_uscore == 8'hff) wrapped = 1'b1;
			exp_uscore = exp_uscore + 1'b1;
		end
		if (exp_out == rps_rules_pkg::OUT_COM_WIN) exp_cscore = exp_cscore + 1'b1;
		check_move({name, " user"}, u, q_user.pop_front());
		check_outcome(name, exp_out, out_seen);
		check_score({name, " user score"}, exp_uscore, q_us.pop_front());
		check_score({name, " com score"}, exp_cscore, q_cs.pop_front());
		check_display(name, exp_uscore, exp_cscore, u, exp_com, q_hex.pop_front());
		if (model_cnt[model_ctx][u] < (1 << COUNT_WIDTH) - 1) model_cnt[model_ctx][u]++;
		model_ctx = u; // learns in every round
	endtask

	initial begin
		int n;
		rps_rules_pkg::move_t com_seen, u;
		rps_rules_pkg::outcome_t out_seen;
		rps_rules_pkg::move_t burst [QUEUE_DEPTH];
		move_valid = 1'b0;
		move       = rps_rules_pkg::MOVE_ROCK;
		strategy   = rps_rules_pkg::STRAT_MARKOV;
		exp_uscore = '0;
		exp_cscore = '0;
		model_ctx  = rps_rules_pkg::MOVE_ROCK;
		model_cnt  = '{default: 0};
		void'($urandom(59494));
		n = 0;
		while (reset !== 1'b1) begin
			@(negedge clock);
			n++;
			if (n > TIMEOUT) give_up("reset release");
		end
		check_score("reset user score", 8'd0, user_score);
		check_score("reset com score", 8'd0, com_score);
		check_display("reset", 8'd0, 8'd0, rps_rules_pkg::MOVE_ROCK, rps_rules_pkg::MOVE_ROCK,
			{hex5, hex4, hex3, hex2, hex1, hex0});
		repeat (10) @(negedge clock);
		if (returned != 0 || q_user.size() != 0) begin
			other_errors++;
			$display("credit_return or result_valid pulsed with nothing sent");
		end
		for (int i = 0; i < NUM_TBL; i++) begin
			send_move(tbl_strat[i], tbl_user[i]);
			release_input();
			collect_round(tbl_name[i], tbl_strat[i], tbl_user[i], com_seen, out_seen);
			if (tbl_strat[i] == rps_rules_pkg::STRAT_MARKOV) begin
				check_move({tbl_name[i], " table com"}, tbl_com[i], com_seen);
				check_outcome({tbl_name[i], " table"}, tbl_out[i], out_seen);
			end
		end
		n = returned;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			burst[i] = rps_rules_pkg::move_t'(2'($urandom % 3));
			send_move(rps_rules_pkg::STRAT_MARKOV, burst[i]);
		end
		release_input();
		for (int i = 0; i < QUEUE_DEPTH; i++)
			collect_round("credit_burst", rps_rules_pkg::STRAT_MARKOV, burst[i], com_seen, out_seen);
		repeat (5) @(negedge clock);
		if (returned - n != QUEUE_DEPTH) begin
			other_errors++;
			$display("burst returned %0d credits instead of %0d", returned - n, QUEUE_DEPTH);
		end
		for (int i = 0; i < 300; i++) begin
			u = ($urandom % 10 < 9) ? beats(model_com())
				: rps_rules_pkg::move_t'(2'($urandom % 3)); // mostly user wins, so scores wrap
			send_move(rps_rules_pkg::STRAT_MARKOV, u);
			release_input();
			collect_round("random_run", rps_rules_pkg::STRAT_MARKOV, u, com_seen, out_seen);
		end
		if (!wrapped) begin
			other_errors++;
			$display("user score never wrapped past 255 in the random run");
		end
		$display("errors: value %0d, other %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- testbench/tb_clock_gen.sv
// tb_clock_gen: 20 ns clock and an active-low reset held for 8 cycles
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin
		reset = 1'b0;
		repeat (8) @(posedge clock);
		@(negedge clock) reset = 1'b1; // release away from the active edge
	end

endmodule

//--- verilog/move_queue.sv
// move_queue: FIFO of submitted moves with a credit returned on each pop
`timescale 1ns/1ps

module move_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     push,
	input  rps_rules_pkg::move_t     push_move,
	input  rps_rules_pkg::strategy_t push_strategy,
	input  logic                     pop,
	output logic                     empty,
	output rps_rules_pkg::move_t     head_move,
	output rps_rules_pkg::strategy_t head_strategy,
	output logic                     credit_return
);

	localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);
	localparam int CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);
	localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(QUEUE_DEPTH - 1);

	rps_rules_pkg::move_t     move_mem [QUEUE_DEPTH];
	rps_rules_pkg::strategy_t strat_mem [QUEUE_DEPTH];
	logic [PTR_WIDTH-1:0]     rd_ptr, wr_ptr;
	logic [CNT_WIDTH-1:0]     count;

	assign empty = (count == '0);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			rd_ptr        <= '0;
			wr_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop; // one credit per entry that leaves
			if (push)
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// storage and the held head entry
	always_ff @(posedge clock) begin
		if (push) begin
			move_mem[wr_ptr]  <= push_move;
			strat_mem[wr_ptr] <= push_strategy;
		end
		if (pop) begin
			head_move     <= move_mem[rd_ptr]; // stays put for the whole round
			head_strategy <= strat_mem[rd_ptr];
		end
	end

endmodule

//--- verilog/opponent_strategy.sv
// opponent_strategy: cyclic player, markov count table and the computer move register
`timescale 1ns/1ps

module opponent_strategy #(
	parameter int COUNT_WIDTH = 8
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     choose,
	input  logic                     learn,
	input  rps_rules_pkg::strategy_t strategy,
	input  rps_rules_pkg::move_t     user_move,
	output rps_rules_pkg::move_t     com_move
);

	localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = {COUNT_WIDTH{1'b1}};

	rps_rules_pkg::move_t   cyc_move;
	rps_rules_pkg::move_t   context_move;    // previous user move
	rps_rules_pkg::move_t   predicted;
	rps_rules_pkg::move_t   counter_move;
	logic [COUNT_WIDTH-1:0] count_table [3][3]; // [previous][next]
	logic [COUNT_WIDTH-1:0] c_rock, c_scissor, c_paper;

	// free-running cyclic player
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			cyc_move <= rps_rules_pkg::MOVE_ROCK;
		end else begin
			case (cyc_move)
				rps_rules_pkg::MOVE_ROCK:    cyc_move <= rps_rules_pkg::MOVE_SCISSOR;
				rps_rules_pkg::MOVE_SCISSOR: cyc_move <= rps_rules_pkg::MOVE_PAPER;
				default:                     cyc_move <= rps_rules_pkg::MOVE_ROCK;
			endcase
		end
	end

	assign c_rock    = count_table[context_move][rps_rules_pkg::MOVE_ROCK];
	assign c_scissor = count_table[context_move][rps_rules_pkg::MOVE_SCISSOR];
	assign c_paper   = count_table[context_move][rps_rules_pkg::MOVE_PAPER];

	// most likely next user move, lower code wins a tie
	always_comb begin
		if (c_rock >= c_scissor && c_rock >= c_paper)
			predicted = rps_rules_pkg::MOVE_ROCK;
		else if (c_scissor >= c_paper)
			predicted = rps_rules_pkg::MOVE_SCISSOR;
		else
			predicted = rps_rules_pkg::MOVE_PAPER;
	end

	assign counter_move = rps_rules_pkg::winning_move(predicted);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			com_move <= rps_rules_pkg::MOVE_ROCK;
		end else if (choose) begin
			com_move <= (strategy == rps_rules_pkg::STRAT_MARKOV) ? counter_move : cyc_move;
		end
	end

	// learning runs every round, whichever player was picked
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			context_move <= rps_rules_pkg::MOVE_ROCK;
			for (int i = 0; i < 3; i++) begin
				for (int j = 0; j < 3; j++) begin
					count_table[i][j] <= '0;
				end
			end
		end else if (learn) begin
			if (count_table[context_move][user_move] != COUNT_MAX)
				count_table[context_move][user_move] <=
					count_table[context_move][user_move] + 1'b1; // saturates
			context_move <= user_move;
		end
	end

endmodule

//--- verilog/round_control.sv
// round_control: round FSM sequencing pop, predict, judge and learn
`timescale 1ns/1ps

module round_control (
	input  logic clock,
	input  logic reset,
	input  logic empty,
	output logic pop,
	output logic choose,
	output logic judge,
	output logic learn
);

	rps_hw_pkg::round_state_t state, next_state;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state <= rps_hw_pkg::ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// a round takes exactly four cycles once started
	always_comb begin
		next_state = state;
		case (state)
			rps_hw_pkg::ST_IDLE: begin
				if (!empty)
					next_state = rps_hw_pkg::ST_PREDICT;
			end
			rps_hw_pkg::ST_PREDICT: begin
				next_state = rps_hw_pkg::ST_JUDGE;
			end
			rps_hw_pkg::ST_JUDGE: begin
				next_state = rps_hw_pkg::ST_LEARN;
			end
			rps_hw_pkg::ST_LEARN: begin
				next_state = rps_hw_pkg::ST_IDLE;
			end
			default: begin
				next_state = rps_hw_pkg::ST_IDLE;
			end
		endcase
	end

	// one strobe per state
	always_comb begin
		pop    = 1'b0;
		choose = 1'b0;
		judge  = 1'b0;
		learn  = 1'b0;
		case (state)
			rps_hw_pkg::ST_IDLE:    pop    = !empty; // head latched at this edge
			rps_hw_pkg::ST_PREDICT: choose = 1'b1;
			rps_hw_pkg::ST_JUDGE:   judge  = 1'b1;
			rps_hw_pkg::ST_LEARN:   learn  = 1'b1;
			default: begin
				pop = 1'b0;
			end
		endcase
	end

endmodule

//--- verilog/round_judge.sv
// round_judge: win rule, registered outcome, shown moves and both scores
`timescale 1ns/1ps

module round_judge (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic                                  judge,
	input  rps_rules_pkg::move_t                  user_move,
	input  rps_rules_pkg::move_t                  com_move,
	output logic                                  result_valid,
	output rps_rules_pkg::outcome_t               outcome,
	output rps_rules_pkg::move_t                  user_move_shown,
	output rps_rules_pkg::move_t                  com_move_shown,
	output logic [rps_rules_pkg::SCORE_WIDTH-1:0] user_score,
	output logic [rps_rules_pkg::SCORE_WIDTH-1:0] com_score
);

	rps_rules_pkg::outcome_t round_result;

	always_comb begin
		if (user_move == com_move)
			round_result = rps_rules_pkg::OUT_DRAW;
		else if (user_move == rps_rules_pkg::winning_move(com_move))
			round_result = rps_rules_pkg::OUT_USER_WIN;
		else
			round_result = rps_rules_pkg::OUT_COM_WIN;
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			result_valid    <= 1'b0;
			outcome         <= rps_rules_pkg::OUT_DRAW;
			user_move_shown <= rps_rules_pkg::MOVE_ROCK;
			com_move_shown  <= rps_rules_pkg::MOVE_ROCK;
			user_score      <= '0;
			com_score       <= '0;
		end else begin
			result_valid <= judge; // one cycle after the judge strobe
			if (judge) begin
				outcome         <= round_result;
				user_move_shown <= user_move;
				com_move_shown  <= com_move;
				if (round_result == rps_rules_pkg::OUT_USER_WIN)
					user_score <= user_score + 1'b1; // wraps at 255
				if (round_result == rps_rules_pkg::OUT_COM_WIN)
					com_score <= com_score + 1'b1;
			end
		end
	end

endmodule

//--- verilog/rps_game_top.sv
// rps_game_top: move queue, opponent, judge, display and round control wired together
`timescale 1ns/1ps

module rps_game_top #(
	parameter int QUEUE_DEPTH = rps_hw_pkg::DEFAULT_QUEUE_DEPTH,
	parameter int COUNT_WIDTH = rps_hw_pkg::DEFAULT_COUNT_WIDTH
) (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic                                  move_valid,
	input  rps_rules_pkg::move_t                  move,
	input  rps_rules_pkg::strategy_t              strategy,
	output logic                                  credit_return,
	output logic                                  result_valid,
	output rps_rules_pkg::outcome_t               outcome,
	output rps_rules_pkg::move_t                  user_move_shown,
	output rps_rules_pkg::move_t                  com_move_shown,
	output logic [rps_rules_pkg::SCORE_WIDTH-1:0] user_score,
	output logic [rps_rules_pkg::SCORE_WIDTH-1:0] com_score,
	output logic [rps_hw_pkg::SEG_WIDTH-1:0]      hex0,
	output logic [rps_hw_pkg::SEG_WIDTH-1:0]      hex1,
	output logic [rps_hw_pkg::SEG_WIDTH-1:0]      hex2,
	output logic [rps_hw_pkg::SEG_WIDTH-1:0]      hex3,
	output logic [rps_hw_pkg::SEG_WIDTH-1:0]      hex4,
	output logic [rps_hw_pkg::SEG_WIDTH-1:0]      hex5
);

	logic                     pop, choose, judge, learn;
	logic                     empty;
	rps_rules_pkg::move_t     head_move;
	rps_rules_pkg::strategy_t head_strategy;
	rps_rules_pkg::move_t     com_move;

	move_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_move_queue (
		.clock(clock), .reset(reset),
		.push(move_valid), .push_move(move), .push_strategy(strategy), // sender holds a credit
		.pop(pop), .empty(empty),
		.head_move(head_move), .head_strategy(head_strategy),
		.credit_return(credit_return)
	);

	round_control u_round_control (
		.clock(clock), .reset(reset), .empty(empty),
		.pop(pop), .choose(choose), .judge(judge), .learn(learn)
	);

	opponent_strategy #(.COUNT_WIDTH(COUNT_WIDTH)) u_opponent_strategy (
		.clock(clock), .reset(reset),
		.choose(choose), .learn(learn),
		.strategy(head_strategy), .user_move(head_move),
		.com_move(com_move)
	);

	round_judge u_round_judge (
		.clock(clock), .reset(reset), .judge(judge),
		.user_move(head_move), .com_move(com_move),
		.result_valid(result_valid), .outcome(outcome),
		.user_move_shown(user_move_shown), .com_move_shown(com_move_shown),
		.user_score(user_score), .com_score(com_score)
	);

	score_display u_score_display (
		.user_score(user_score), .com_score(com_score),
		.user_move_shown(user_move_shown), .com_move_shown(com_move_shown),
		.hex0(hex0), .hex1(hex1), .hex2(hex2),
		.hex3(hex3), .hex4(hex4), .hex5(hex5)
	);

endmodule

//--- verilog/rps_hw_pkg.sv
// hardware plumbing: round state type, segment width and default sizes
package rps_hw_pkg;

	// one round walks through all four states
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_PREDICT = 2'd1,
		ST_JUDGE   = 2'd2,
		ST_LEARN   = 2'd3
	} round_state_t;

	localparam int SEG_WIDTH = 7; // segments g..a, active low

	localparam int DEFAULT_QUEUE_DEPTH = 4; // credits held by the sender
	localparam int DEFAULT_COUNT_WIDTH = 8; // markov counter width

endpackage

//--- verilog/rps_rules_pkg.sv
// game rules: move, outcome and strategy types, score width and the win rule
package rps_rules_pkg;

	// move codes as shown on the hex digits
	typedef enum logic [1:0] {
		MOVE_ROCK    = 2'd0,
		MOVE_SCISSOR = 2'd1,
		MOVE_PAPER   = 2'd2
	} move_t;

	// result of one round, seen from the user side
	typedef enum logic [1:0] {
		OUT_DRAW     = 2'd0,
		OUT_USER_WIN = 2'd1,
		OUT_COM_WIN  = 2'd2
	} outcome_t;

	typedef enum logic {
		STRAT_CYCLIC = 1'b0, // free-running count
		STRAT_MARKOV = 1'b1  // transition-count prediction
	} strategy_t;

	localparam int SCORE_WIDTH = 8; // two hex digits per score

	// the move that beats m: rock > scissor > paper > rock
	function automatic move_t winning_move(input move_t m);
		case (m)
			MOVE_ROCK:    return MOVE_PAPER;
			MOVE_SCISSOR: return MOVE_ROCK;
			default:      return MOVE_SCISSOR;
		endcase
	endfunction

endpackage

//--- verilog/score_display.sv
// score_display: seven-segment decoding of both scores and both moves
`timescale 1ns/1ps

module score_display (
	input  logic [rps_rules_pkg::SCORE_WIDTH-1:0] user_score,
	input  logic [rps_rules_pkg::SCORE_WIDTH-1:0] com_score,
	input  rps_rules_pkg::move_t                  user_move_shown,
	input  rps_rules_pkg::move_t                  com_move_shown,
	output logic [rps_hw_pkg::SEG_WIDTH-1:0]      hex0,
	output logic [rps_hw_pkg::SEG_WIDTH-1:0]      hex1,
	output logic [rps_hw_pkg::SEG_WIDTH-1:0]      hex2,
	output logic [rps_hw_pkg::SEG_WIDTH-1:0]      hex3,
	output logic [rps_hw_pkg::SEG_WIDTH-1:0]      hex4,
	output logic [rps_hw_pkg::SEG_WIDTH-1:0]      hex5
);

	// active low, bit 6 is segment g
	function automatic logic [rps_hw_pkg::SEG_WIDTH-1:0] seg_of(input logic [3:0] nib);
		case (nib)
			4'h0: return 7'b100_0000;
			4'h1: return 7'b111_1001;
			4'h2: return 7'b010_0100;
			4'h3: return 7'b011_0000;
			4'h4: return 7'b001_1001;
			4'h5: return 7'b001_0010;
			4'h6: return 7'b000_0010;
			4'h7: return 7'b111_1000;
			4'h8: return 7'b000_0000;
			4'h9: return 7'b001_1000;
			4'ha: return 7'b000_1000;
			4'hb: return 7'b000_0011;
			4'hc: return 7'b100_0110;
			4'hd: return 7'b010_0001;
			4'he: return 7'b000_0110;
			default: return 7'b000_1110;
		endcase
	endfunction

	assign hex0 = seg_of(user_score[3:0]);
	assign hex1 = seg_of(user_score[rps_rules_pkg::SCORE_WIDTH-1 -: 4]);
	assign hex2 = seg_of({2'b00, user_move_shown}); // move code as a digit
	assign hex3 = seg_of({2'b00, com_move_shown});
	assign hex4 = seg_of(com_score[3:0]);
	assign hex5 = seg_of(com_score[rps_rules_pkg::SCORE_WIDTH-1 -: 4]);

endmodule
